// ==== src/dbg_macros.svh ====
// ======================================================================
// bus widths for the debug peripheral port
// register map of the console, timer and completion registers
// ======================================================================

`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// bus widths
`define DBG_ID_W 4
`define DBG_ADDR_W 32
`define DBG_DATA_W 64
`define DBG_STRB_W 8

// register map
`define DBG_ADDR_UART 32'h20000000 // console character
`define DBG_ADDR_TIMER 32'h20000008 // start/stop and live count
`define DBG_ADDR_CTRL_DHRY 32'h20000010 // dhrystone finished
`define DBG_ADDR_CTRL_CORE 32'h20000020 // coremark finished

`endif

// ==== src/dbg_axi_pkg.sv ====
// ======================================================================
// channel payload structs of the AXI-style slave port
// write address, write data, write response, read address, read data
// ======================================================================

`include "dbg_macros.svh"

package dbg_axi_pkg;

	typedef struct packed {
		logic [`DBG_ID_W-1:0] id;
		logic [`DBG_ADDR_W-1:0] addr;
	} aw_t;

	typedef struct packed {
		logic [`DBG_DATA_W-1:0] data;
		logic [`DBG_STRB_W-1:0] strb;
	} w_t;

	typedef struct packed {
		logic [`DBG_ID_W-1:0] id;
		logic [1:0] resp; // always okay
	} b_t;

	typedef struct packed {
		logic [`DBG_ID_W-1:0] id;
		logic [`DBG_ADDR_W-1:0] addr;
	} ar_t;

	typedef struct packed {
		logic [`DBG_ID_W-1:0] id;
		logic [`DBG_DATA_W-1:0] data;
		logic [1:0] resp; // always okay
	} r_t;

endpackage

// ==== src/dbg_reg_pkg.sv ====
// ======================================================================
// register side types: benchmark kind, accepted write,
// write data views and the completion report
// ======================================================================

`include "dbg_macros.svh"

package dbg_reg_pkg;

	typedef enum logic [1:0] {
		bench_none = 2'd0,
		bench_dhrystone = 2'd1,
		bench_coremark = 2'd2
	} bench_e;

	// one data word, seen as a command or as a console character
	typedef union packed {
		logic [`DBG_DATA_W-1:0] cmd;
		struct packed {
			logic [`DBG_DATA_W-9:0] unused;
			logic [7:0] ch;
		} chr;
	} wdata_u;

	typedef struct packed {
		logic strb; // write accepted this cycle
		logic [`DBG_ADDR_W-1:0] addr;
		wdata_u data;
	} reg_wr_t;

	typedef struct packed {
		logic success;
		bench_e bench;
		logic [`DBG_DATA_W-1:0] cycles; // count at completion
	} result_t;

endpackage

// ==== src/dbg_wr_ctrl.sv ====
// ======================================================================
// write channel controller: awready/wready/bvalid handshake flops,
// BID capture and the register write strobe
// ======================================================================

`timescale 1ns/1ns
`include "dbg_macros.svh"

module dbg_wr_ctrl (
	input logic CLK,
	input logic RSTn,
	input dbg_axi_pkg::aw_t aw,
	input logic awvalid,
	output logic awready,
	input dbg_axi_pkg::w_t w,
	input logic wvalid,
	output logic wready,
	output dbg_axi_pkg::b_t b,
	output logic bvalid,
	input logic bready,
	output dbg_reg_pkg::reg_wr_t reg_wr
);

	logic ready_set; // both readies rise together
	logic accept;
	logic b_done;
	logic [`DBG_ID_W-1:0] bid;

	assign ready_set = ~awready & awvalid & wvalid;
	assign accept = awvalid & awready & wvalid & wready;
	assign b_done = bvalid & bready;

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (ready_set)
				awready <= 1'b1;
			else if (b_done)
				awready <= 1'b0; // held until response taken
			wready <= ready_set; // single cycle pulse
			if (accept)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept)
			bid <= aw.id;
	end

	assign b.id = bid;
	assign b.resp = 2'b00;

	assign reg_wr.strb = accept;
	assign reg_wr.addr = aw.addr;
	assign reg_wr.data.cmd = w.data;

	// response and its ID are held until the master takes them
	assert property (@(posedge CLK) disable iff (!RSTn)
		bvalid && !bready |=> bvalid && $stable(b));

	assert property (@(posedge CLK) disable iff (!RSTn)
		wready |=> !wready);

endmodule

// ==== src/dbg_rd_ctrl.sv ====
// ======================================================================
// read channel controller: arready pulse, rvalid hold,
// RID and read data capture
// ======================================================================

`timescale 1ns/1ns
`include "dbg_macros.svh"

module dbg_rd_ctrl (
	input logic CLK,
	input logic RSTn,
	input dbg_axi_pkg::ar_t ar,
	input logic arvalid,
	output logic arready,
	output dbg_axi_pkg::r_t r,
	output logic rvalid,
	input logic rready,
	output logic [`DBG_ADDR_W-1:0] rd_addr,
	input logic [`DBG_DATA_W-1:0] rd_data
);

	logic accept;
	logic [`DBG_ID_W-1:0] rid;
	logic [`DBG_DATA_W-1:0] rdata;

	assign accept = arvalid & arready;
	assign rd_addr = ar.addr; // register lookup is combinational

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= ~arready & ~rvalid & arvalid; // pulse only when idle
			if (accept)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			rid <= ar.id;
			rdata <= rd_data; // sampled at accept
		end
	end

	assign r.id = rid;
	assign r.data = rdata;
	assign r.resp = 2'b00;

	assert property (@(posedge CLK) disable iff (!RSTn)
		rvalid && !rready |=> rvalid && $stable(r));

endmodule

// ==== src/dbg_regs.sv ====
// ======================================================================
// console, cycle timer and benchmark completion registers
// plus the combinational read lookup
// ======================================================================

`timescale 1ns/1ns
`include "dbg_macros.svh"

module dbg_regs (
	input logic CLK,
	input logic RSTn,
	input dbg_reg_pkg::reg_wr_t reg_wr,
	input logic [`DBG_ADDR_W-1:0] rd_addr,
	output logic [`DBG_DATA_W-1:0] rd_data,
	output logic uart_valid,
	output logic [7:0] uart_char,
	output dbg_reg_pkg::result_t result
);

	logic hit_uart;
	logic hit_timer;
	logic hit_dhry;
	logic hit_core;
	logic cmd_one;
	logic cmd_zero;
	logic timer_run;
	logic [`DBG_DATA_W-1:0] cycle_cnt;

	assign hit_uart = reg_wr.strb && (reg_wr.addr == `DBG_ADDR_UART);
	assign hit_timer = reg_wr.strb && (reg_wr.addr == `DBG_ADDR_TIMER);
	assign hit_dhry = reg_wr.strb && (reg_wr.addr == `DBG_ADDR_CTRL_DHRY);
	assign hit_core = reg_wr.strb && (reg_wr.addr == `DBG_ADDR_CTRL_CORE);
	assign cmd_one = (reg_wr.data.cmd == `DBG_DATA_W'(1));
	assign cmd_zero = (reg_wr.data.cmd == '0);

	// console strobe, one cycle per accepted write
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn)
			uart_valid <= 1'b0;
		else
			uart_valid <= hit_uart;
	end

	always_ff @(posedge CLK) begin
		if (hit_uart)
			uart_char <= reg_wr.data.chr.ch; // low byte only
	end

	// the count lags the run flag by one edge, so the start edge
	// itself is not counted but the stop edge is
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			timer_run <= 1'b0;
			cycle_cnt <= '0;
		end else begin
			if (hit_timer && cmd_one)
				timer_run <= 1'b1;
			else if (hit_timer && cmd_zero)
				timer_run <= 1'b0;
			if (timer_run)
				cycle_cnt <= cycle_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			result <= '0;
		end else if ((hit_dhry || hit_core) && cmd_one) begin
			result.success <= 1'b1; // sticky until reset
			result.bench <= hit_core ? dbg_reg_pkg::bench_coremark :
				dbg_reg_pkg::bench_dhrystone;
			result.cycles <= cycle_cnt;
		end
	end

	assign rd_data = (rd_addr == `DBG_ADDR_TIMER) ? cycle_cnt : '0;

	assert property (@(posedge CLK) disable iff (!RSTn)
		!timer_run |=> $stable(cycle_cnt));

endmodule

// ==== src/dbg_top.sv ====
// ======================================================================
// debug peripheral top: write and read channel controllers
// joined to the register block
// ======================================================================

`timescale 1ns/1ns
`include "dbg_macros.svh"

module dbg_top (
	input logic CLK,
	input logic RSTn,
	input dbg_axi_pkg::aw_t aw,
	input logic awvalid,
	output logic awready,
	input dbg_axi_pkg::w_t w,
	input logic wvalid,
	output logic wready,
	output dbg_axi_pkg::b_t b,
	output logic bvalid,
	input logic bready,
	input dbg_axi_pkg::ar_t ar,
	input logic arvalid,
	output logic arready,
	output dbg_axi_pkg::r_t r,
	output logic rvalid,
	input logic rready,
	output logic uart_valid,
	output logic [7:0] uart_char,
	output dbg_reg_pkg::result_t result
);

	dbg_reg_pkg::reg_wr_t reg_wr;
	logic [`DBG_ADDR_W-1:0] rd_addr;
	logic [`DBG_DATA_W-1:0] rd_data;

	dbg_wr_ctrl wr_ctrl_i (
		.CLK(CLK), .RSTn(RSTn),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.reg_wr(reg_wr)
	);

	dbg_rd_ctrl rd_ctrl_i (
		.CLK(CLK), .RSTn(RSTn),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	dbg_regs regs_i (
		.CLK(CLK), .RSTn(RSTn),
		.reg_wr(reg_wr),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.uart_valid(uart_valid), .uart_char(uart_char),
		.result(result)
	);

endmodule

// ==== sim/tb_dbg_top.sv ====
// ======================================================================
// testbench for the debug peripheral: operation table, bus tasks,
// transfer monitors, timer model and watchdog
// ======================================================================

`timescale 1ns/1ns
`include "dbg_macros.svh"

module tb_dbg_top;

	typedef struct packed {
		logic is_wr;
		logic use_cnt; // expect the modelled cycle count
		logic [`DBG_ADDR_W-1:0] addr;
		logic [`DBG_DATA_W-1:0] data;
		logic [`DBG_DATA_W-1:0] exp; // read data or console character
	} op_t;

	localparam int N_OPS = 18;
	localparam int WATCHDOG_NS = (N_OPS * 200 + 10) * 10;

	logic CLK;
	logic RSTn;
	dbg_axi_pkg::aw_t aw;
	logic awvalid;
	logic awready;
	dbg_axi_pkg::w_t w;
	logic wvalid;
	logic wready;
	dbg_axi_pkg::b_t b;
	logic bvalid;
	logic bready;
	dbg_axi_pkg::ar_t ar;
	logic arvalid;
	logic arready;
	dbg_axi_pkg::r_t r;
	logic rvalid;
	logic rready;
	logic uart_valid;
	logic [7:0] uart_char;
	dbg_reg_pkg::result_t result;

	op_t ops [N_OPS];
	int errors = 0;
	int checks = 0;
	int edge_cnt = 0; // rising edges seen so far
	int b_xfers = 0;
	int r_xfers = 0;
	int uart_pulses = 0;
	logic [7:0] last_char;
	int accept_edge; // edge that took the last write

	dbg_top dut_i (.*);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		edge_cnt <= edge_cnt + 1;
		if (bvalid && bready)
			b_xfers <= b_xfers + 1;
		if (rvalid && rready)
			r_xfers <= r_xfers + 1;
		if (uart_valid) begin
			uart_pulses <= uart_pulses + 1;
			last_char <= uart_char;
		end
	end

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic do_write(input logic [3:0] id, input logic [31:0] addr,
		input logic [63:0] data);
		int stall;
		aw = '{id, addr};
		w = '{data, 8'hff};
		awvalid = 1'b1;
		wvalid = 1'b1;
		do
			@(negedge CLK);
		while (!(awready && wready));
		accept_edge = edge_cnt + 1; // the coming edge takes the write
		@(negedge CLK);
		awvalid = 1'b0;
		wvalid = 1'b0;
		stall = $urandom_range(3, 0);
		repeat (stall) begin
			check_equal(bvalid, 1'b1, "bvalid during stall");
			check_equal({b.id, b.resp}, {id, 2'b00}, "b payload during stall");
			@(negedge CLK);
		end
		check_equal(bvalid, 1'b1, "bvalid");
		check_equal({b.id, b.resp}, {id, 2'b00}, "b id and resp");
		bready = 1'b1;
		@(negedge CLK);
		bready = 1'b0;
		check_equal(bvalid, 1'b0, "bvalid after transfer");
	endtask

	task automatic do_read(input logic [3:0] id, input logic [31:0] addr,
		input logic [63:0] exp);
		int stall;
		ar = '{id, addr};
		arvalid = 1'b1;
		do
			@(negedge CLK);
		while (!arready);
		@(negedge CLK);
		arvalid = 1'b0;
		stall = $urandom_range(3, 0);
		repeat (stall) begin
			check_equal(rvalid, 1'b1, "rvalid during stall");
			check_equal(r.data, exp, "r data during stall");
			check_equal({r.id, r.resp}, {id, 2'b00}, "r id during stall");
			@(negedge CLK);
		end
		check_equal(rvalid, 1'b1, "rvalid");
		check_equal(r.data, exp, "r data");
		check_equal({r.id, r.resp}, {id, 2'b00}, "r id and resp");
		rready = 1'b1;
		@(negedge CLK);
		rready = 1'b0;
		check_equal(rvalid, 1'b0, "rvalid after transfer");
	endtask

	initial begin
		int b_before;
		int r_before;
		int pulses_before;
		int start_edge;
		logic [3:0] id;
		logic [63:0] cnt_model;
		logic [63:0] exp_cycles;
		logic exp_success;
		dbg_reg_pkg::bench_e exp_bench;

		void'($urandom(32'hb413));
		RSTn = 1'b0;
		aw = '0;
		awvalid = 1'b0;
		w = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		ar = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		cnt_model = '0;
		exp_cycles = '0;
		exp_success = 1'b0;
		exp_bench = dbg_reg_pkg::bench_none;
		start_edge = 0;

		ops[0] = '{1'b0, 1'b1, `DBG_ADDR_TIMER, 64'd0, 64'd0};
		ops[1] = '{1'b1, 1'b0, `DBG_ADDR_UART, 64'h41, 64'h41};
		ops[2] = '{1'b1, 1'b0, `DBG_ADDR_UART, 64'hdeadbeef_cafe0a42, 64'h42};
		ops[3] = '{1'b0, 1'b0, `DBG_ADDR_UART, 64'd0, 64'd0};
		ops[4] = '{1'b1, 1'b0, `DBG_ADDR_TIMER, 64'd1, 64'd0}; // start
		ops[5] = '{1'b1, 1'b0, `DBG_ADDR_UART, 64'hffffffff_ffffff43, 64'h43};
		ops[6] = '{1'b0, 1'b0, `DBG_ADDR_CTRL_DHRY, 64'd0, 64'd0};
		ops[7] = '{1'b1, 1'b0, `DBG_ADDR_TIMER, 64'd0, 64'd0}; // stop
		ops[8] = '{1'b0, 1'b1, `DBG_ADDR_TIMER, 64'd0, 64'd0};
		ops[9] = '{1'b0, 1'b1, `DBG_ADDR_TIMER, 64'd0, 64'd0}; // same count after idle
		ops[10] = '{1'b1, 1'b0, `DBG_ADDR_CTRL_CORE, 64'd0, 64'd0};
		ops[11] = '{1'b1, 1'b0, `DBG_ADDR_TIMER, 64'd1, 64'd0};
		ops[12] = '{1'b1, 1'b0, `DBG_ADDR_UART, 64'h0a, 64'h0a};
		ops[13] = '{1'b1, 1'b0, `DBG_ADDR_TIMER, 64'd0, 64'd0};
		ops[14] = '{1'b0, 1'b1, `DBG_ADDR_TIMER, 64'd0, 64'd0};
		ops[15] = '{1'b1, 1'b0, `DBG_ADDR_CTRL_CORE, 64'd1, 64'd0}; // coremark done
		ops[16] = '{1'b1, 1'b0, `DBG_ADDR_CTRL_DHRY, 64'd0, 64'd0};
		ops[17] = '{1'b0, 1'b0, `DBG_ADDR_CTRL_CORE, 64'd0, 64'd0};

		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RSTn = 1'b1;
		check_equal({awready, wready, bvalid, arready, rvalid, uart_valid, result.success},
			7'd0, "outputs after reset");

		for (int i = 0; i < N_OPS; i++) begin
			repeat ($urandom_range(4, 1)) @(negedge CLK);
			id = 4'($urandom_range(15, 0));
			b_before = b_xfers;
			r_before = r_xfers;
			pulses_before = uart_pulses;
			if (ops[i].is_wr) begin
				do_write(id, ops[i].addr, ops[i].data);
				if (ops[i].addr == `DBG_ADDR_TIMER && ops[i].data == 64'd1)
					start_edge = accept_edge;
				if (ops[i].addr == `DBG_ADDR_TIMER && ops[i].data == 64'd0)
					cnt_model = cnt_model + 64'(accept_edge - start_edge);
				if ((ops[i].addr == `DBG_ADDR_CTRL_DHRY || ops[i].addr == `DBG_ADDR_CTRL_CORE)
					&& ops[i].data == 64'd1) begin
					exp_success = 1'b1;
					exp_bench = (ops[i].addr == `DBG_ADDR_CTRL_CORE) ?
						dbg_reg_pkg::bench_coremark : dbg_reg_pkg::bench_dhrystone;
					exp_cycles = cnt_model;
				end
			end else begin
				do_read(id, ops[i].addr, ops[i].use_cnt ? cnt_model : ops[i].exp);
			end
			@(negedge CLK); // a second console pulse would show here
			check_equal(b_xfers - b_before, ops[i].is_wr, "b transfers");
			check_equal(r_xfers - r_before, !ops[i].is_wr, "r transfers");
			check_equal(uart_pulses - pulses_before,
				ops[i].is_wr && ops[i].addr == `DBG_ADDR_UART, "uart pulses");
			if (ops[i].is_wr && ops[i].addr == `DBG_ADDR_UART)
				check_equal(last_char, ops[i].exp[7:0], "uart char");
			check_equal(result.success, exp_success, "result success");
			check_equal(result.bench, exp_bench, "result bench");
			check_equal(result.cycles, exp_cycles, "result cycles");
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout: a bus handshake did not complete in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+src
src/dbg_axi_pkg.sv
src/dbg_reg_pkg.sv
src/dbg_wr_ctrl.sv
src/dbg_rd_ctrl.sv
src/dbg_regs.sv
src/dbg_top.sv
sim/tb_dbg_top.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the debug peripheral testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_dbg_top \
	&& ./obj_dir/Vtb_dbg_top | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
